// File: hdl/cl_hello_pkg.sv
// ------------------------------
// Shared widths, response codes and
// register map of the hello register block
// ------------------------------
`default_nettype none

package cl_hello_pkg;

  // ------------------------------
  // Register port
  // ------------------------------
  typedef logic [31:0] ocl_addr_t;
  typedef logic [31:0] ocl_data_t;
  typedef logic [1:0]  ocl_resp_t;

  // One bit per virtual LED or DIP switch
  typedef logic [15:0] vled_t;

  // Write side phase
  typedef enum logic {
    WR_IDLE = 1'b0,
    WR_BUSY = 1'b1
  } wr_phase_t;

  // ------------------------------
  // Fixed values
  // ------------------------------
  localparam ocl_resp_t RESP_OKAY    = 2'b00;
  localparam ocl_data_t UNIMPL_VALUE = 32'hdead_dead;

  // Default register map
  localparam ocl_addr_t HELLO_ADDR_DEFAULT = 32'h0000_0500;
  localparam ocl_addr_t VLED_ADDR_DEFAULT  = 32'h0000_0504;

endpackage

`default_nettype wire

// File: hdl/ocl_write_ctrl.sv
// ------------------------------
// Register port write side, takes address then
// data and returns a single okay response
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ocl_write_ctrl (
  input  wire logic                    clk_main_a0,
  input  wire logic                    rst_main_n_sync,
  input  wire logic                    awvalid,
  input  wire cl_hello_pkg::ocl_addr_t awaddr,
  output logic                         awready,
  input  wire logic                    wvalid,
  input  wire cl_hello_pkg::ocl_data_t wdata,
  output logic                         wready,
  output logic                         bvalid,
  output cl_hello_pkg::ocl_resp_t      bresp,
  input  wire logic                    bready,
  output logic                         wr_en,
  output cl_hello_pkg::ocl_addr_t      wr_addr,
  output cl_hello_pkg::ocl_data_t      wr_data
);

  cl_hello_pkg::wr_phase_t phase_q;
  cl_hello_pkg::ocl_addr_t addr_q;
  logic                    aw_xfer;
  logic                    b_xfer;

  assign aw_xfer = awvalid && awready;
  assign b_xfer  = bvalid && bready;

  // ------------------------------
  // Address phase
  // ------------------------------
  assign awready = (phase_q == cl_hello_pkg::WR_IDLE);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      phase_q <= cl_hello_pkg::WR_IDLE;
    end else if (b_xfer) begin
      phase_q <= cl_hello_pkg::WR_IDLE;
    end else if (aw_xfer) begin
      phase_q <= cl_hello_pkg::WR_BUSY;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_xfer) begin
      addr_q <= awaddr;
    end
  end

  // ------------------------------
  // Data phase
  // ------------------------------
  // Data is taken in the same cycle it shows up
  assign wready  = (phase_q == cl_hello_pkg::WR_BUSY) && wvalid;

  assign wr_en   = wready;
  assign wr_addr = addr_q;
  assign wr_data = wdata;

  // ------------------------------
  // Response
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (b_xfer) begin
      bvalid <= 1'b0;
    end else if (wready) begin
      bvalid <= 1'b1;
    end
  end

  assign bresp = cl_hello_pkg::RESP_OKAY;

  // No new address while a response is still pending
  a_bvalid_blocks_aw : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid |-> !awready
  ) else $error("awready high while a write response is pending");

endmodule

`default_nettype wire

// File: hdl/ocl_read_ctrl.sv
// ------------------------------
// Register port read side, decodes the address
// and returns data two cycles after acceptance
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ocl_read_ctrl #(
  parameter cl_hello_pkg::ocl_addr_t hello_addr = cl_hello_pkg::HELLO_ADDR_DEFAULT,
  parameter cl_hello_pkg::ocl_addr_t vled_addr  = cl_hello_pkg::VLED_ADDR_DEFAULT
) (
  input  wire logic                    clk_main_a0,
  input  wire logic                    rst_main_n_sync,
  input  wire logic                    arvalid,
  input  wire cl_hello_pkg::ocl_addr_t araddr,
  output logic                         arready,
  output logic                         rvalid,
  output cl_hello_pkg::ocl_data_t      rdata,
  output cl_hello_pkg::ocl_resp_t      rresp,
  input  wire logic                    rready,
  input  wire cl_hello_pkg::ocl_data_t hello_swapped,
  input  wire cl_hello_pkg::vled_t     vled
);

  logic                    arvalid_q;
  cl_hello_pkg::ocl_addr_t araddr_q;
  cl_hello_pkg::ocl_data_t rdata_sel;

  // ------------------------------
  // Request
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      arvalid_q <= 1'b0;
    end else begin
      arvalid_q <= arvalid;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid) begin
      araddr_q <= araddr;
    end
  end

  // One read in flight at a time
  assign arready = !arvalid_q && !rvalid;

  // ------------------------------
  // Decode
  // ------------------------------
  always_comb begin
    if (araddr_q == hello_addr) begin
      rdata_sel = hello_swapped;
    end else if (araddr_q == vled_addr) begin
      rdata_sel = cl_hello_pkg::ocl_data_t'(vled);
    end else begin
      rdata_sel = cl_hello_pkg::UNIMPL_VALUE;
    end
  end

  // ------------------------------
  // Response
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= cl_hello_pkg::RESP_OKAY;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= cl_hello_pkg::RESP_OKAY;
    end else if (arvalid_q) begin
      rvalid <= 1'b1;
      rdata  <= rdata_sel;
      rresp  <= cl_hello_pkg::RESP_OKAY;
    end
  end

  // Data held steady under back-pressure
  a_rdata_stable : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> $stable(rdata)
  ) else $error("rdata changed while waiting for rready");

endmodule

`default_nettype wire

// File: hdl/hello_regs.sv
// ------------------------------
// Greeting register with byte-swapped
// read view and the LED shadow
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module hello_regs #(
  parameter cl_hello_pkg::ocl_addr_t hello_addr = cl_hello_pkg::HELLO_ADDR_DEFAULT
) (
  input  wire logic                    clk_main_a0,
  input  wire logic                    rst_main_n_sync,
  input  wire logic                    wr_en,
  input  wire cl_hello_pkg::ocl_addr_t wr_addr,
  input  wire cl_hello_pkg::ocl_data_t wr_data,
  output cl_hello_pkg::ocl_data_t      hello_swapped,
  output cl_hello_pkg::vled_t          vled
);

  cl_hello_pkg::ocl_data_t hello_q;
  logic                    hello_wr;

  // Other addresses are silently dropped
  assign hello_wr = wr_en && (wr_addr == hello_addr);

  // ------------------------------
  // Greeting register
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
    end else if (hello_wr) begin
      hello_q <= wr_data;
    end
  end

  // Byte 0 comes back in the top lane
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // ------------------------------
  // LED shadow
  // ------------------------------
  // Follows the low half one cycle late
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled <= '0;
    end else begin
      vled <= hello_q[15:0];
    end
  end

endmodule

`default_nettype wire

// File: hdl/vdip_led_mask.sv
// ------------------------------
// DIP switch synchronizer and masked
// LED status output
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module vdip_led_mask #(
  parameter int sync_stages = 2
) (
  input  wire logic                clk_main_a0,
  input  wire logic                rst_main_n_sync,
  input  wire cl_hello_pkg::vled_t vled,
  input  wire cl_hello_pkg::vled_t status_vdip,
  output cl_hello_pkg::vled_t      status_vled
);

  // Oldest sample sits in the top entry
  cl_hello_pkg::vled_t [sync_stages-1:0] vdip_sync_q;

  if (sync_stages < 2) begin : g_stage_check
    $error("vdip_led_mask needs at least two synchronizer stages");
  end

  // ------------------------------
  // DIP synchronizer
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_sync_q <= '0;
    end else begin
      vdip_sync_q <= {vdip_sync_q[sync_stages-2:0], status_vdip};
    end
  end

  // ------------------------------
  // LED output
  // ------------------------------
  // A switch that is off hides its LED
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      status_vled <= '0;
    end else begin
      status_vled <= vled & vdip_sync_q[sync_stages-1];
    end
  end

endmodule

`default_nettype wire

// File: hdl/cl_hello_top.sv
// ------------------------------
// Hello register block, register port with
// greeting and virtual LED registers
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cl_hello_top #(
  parameter cl_hello_pkg::ocl_addr_t hello_addr  = cl_hello_pkg::HELLO_ADDR_DEFAULT,
  parameter cl_hello_pkg::ocl_addr_t vled_addr   = cl_hello_pkg::VLED_ADDR_DEFAULT,
  parameter int                      sync_stages = 2
) (
  input  wire logic                    clk_main_a0,
  input  wire logic                    rst_main_n_sync,
  // Write address and data
  input  wire logic                    awvalid,
  input  wire cl_hello_pkg::ocl_addr_t awaddr,
  output logic                         awready,
  input  wire logic                    wvalid,
  input  wire cl_hello_pkg::ocl_data_t wdata,
  output logic                         wready,
  // Write response
  output logic                         bvalid,
  output cl_hello_pkg::ocl_resp_t      bresp,
  input  wire logic                    bready,
  // Read address and data
  input  wire logic                    arvalid,
  input  wire cl_hello_pkg::ocl_addr_t araddr,
  output logic                         arready,
  output logic                         rvalid,
  output cl_hello_pkg::ocl_data_t      rdata,
  output cl_hello_pkg::ocl_resp_t      rresp,
  input  wire logic                    rready,
  // Virtual switches and LEDs
  input  wire cl_hello_pkg::vled_t     status_vdip,
  output cl_hello_pkg::vled_t          status_vled
);

  logic                    wr_en;
  cl_hello_pkg::ocl_addr_t wr_addr;
  cl_hello_pkg::ocl_data_t wr_data;
  cl_hello_pkg::ocl_data_t hello_swapped;
  cl_hello_pkg::vled_t     vled;

  // ------------------------------
  // Register port
  // ------------------------------
  ocl_write_ctrl u_write_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data)
  );

  ocl_read_ctrl #(
    .hello_addr (hello_addr),
    .vled_addr  (vled_addr)
  ) u_read_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .hello_swapped   (hello_swapped),
    .vled            (vled)
  );

  // ------------------------------
  // Registers and LEDs
  // ------------------------------
  hello_regs #(
    .hello_addr (hello_addr)
  ) u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .hello_swapped   (hello_swapped),
    .vled            (vled)
  );

  vdip_led_mask #(
    .sync_stages (sync_stages)
  ) u_led_mask (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vled            (vled),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

endmodule

`default_nettype wire

// File: test/tb_cl_hello.sv
// ------------------------------
// Table-driven testbench for the hello
// register block with a reference model
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cl_hello;

  localparam logic [31:0] HELLO_ADDR  = 32'h0000_0500;
  localparam logic [31:0] VLED_ADDR   = 32'h0000_0504;
  localparam logic [31:0] UNMAPPED    = 32'hdead_dead;
  localparam int          SYNC_STAGES = 2;
  localparam int          NUM_ENTRIES = 16;
  localparam logic [1:0]  OP_WRITE    = 2'd0;
  localparam logic [1:0]  OP_READ     = 2'd1;
  localparam logic [1:0]  OP_DIP      = 2'd2;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        awvalid;
  logic [31:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;
  logic        arvalid;
  logic [31:0] araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rready;
  logic [15:0] status_vdip;
  logic [15:0] status_vled;

  // Stimulus table, expected columns filled by the model
  logic [1:0]  tbl_op        [NUM_ENTRIES];
  logic [31:0] tbl_addr      [NUM_ENTRIES];
  logic [31:0] tbl_data      [NUM_ENTRIES];
  logic [31:0] tbl_exp_rdata [NUM_ENTRIES];
  logic [15:0] tbl_exp_led   [NUM_ENTRIES];
  int          n_entries;

  // Reference model state
  logic [31:0] model_hello;
  logic [15:0] model_dip;

  cl_hello_top #(
    .hello_addr  (HELLO_ADDR),
    .vled_addr   (VLED_ADDR),
    .sync_stages (SYNC_STAGES)
  ) uut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #5 clk_main_a0 = ~clk_main_a0;
  end

  // Budget of 40 cycles per entry plus reset and settling
  initial begin
    repeat (40 * NUM_ENTRIES + 200) @(posedge clk_main_a0);
    $display("Run timed out waiting for a handshake from the DUT");
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "Stopping on first mismatch");
    end
  endtask

  function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  // ------------------------------
  // Table construction
  // ------------------------------
  task automatic add_entry(input logic [1:0] op, input logic [31:0] addr,
                           input logic [31:0] data);
    logic [31:0] exp_rd;
    exp_rd = '0;
    if (op == OP_WRITE && addr == HELLO_ADDR) begin
      model_hello = data;
    end else if (op == OP_DIP) begin
      model_dip = data[15:0];
    end else if (op == OP_READ) begin
      if (addr == HELLO_ADDR) begin
        exp_rd = reverse_bytes(model_hello);
      end else if (addr == VLED_ADDR) begin
        exp_rd = {16'h0000, model_hello[15:0]};
      end else begin
        exp_rd = UNMAPPED;
      end
    end
    tbl_op[n_entries]        = op;
    tbl_addr[n_entries]      = addr;
    tbl_data[n_entries]      = data;
    tbl_exp_rdata[n_entries] = exp_rd;
    tbl_exp_led[n_entries]   = model_hello[15:0] & model_dip;
    n_entries++;
  endtask

  task automatic build_table();
    n_entries   = 0;
    model_hello = '0;
    model_dip   = '0;
    add_entry(OP_WRITE, HELLO_ADDR, 32'h4865_6c6c);
    add_entry(OP_READ,  HELLO_ADDR, '0);
    add_entry(OP_READ,  VLED_ADDR,  '0);
    add_entry(OP_DIP,   '0,         32'h0000_ffff);
    add_entry(OP_READ,  32'h0000_0600, '0);
    add_entry(OP_WRITE, 32'h0000_0508, $urandom);
    add_entry(OP_READ,  HELLO_ADDR, '0);
    add_entry(OP_DIP,   '0,         32'h0000_0f0f);
    add_entry(OP_WRITE, HELLO_ADDR, $urandom);
    add_entry(OP_READ,  HELLO_ADDR, '0);
    add_entry(OP_READ,  VLED_ADDR,  '0);
    add_entry(OP_DIP,   '0,         {16'h0000, 16'($urandom)});
    add_entry(OP_WRITE, HELLO_ADDR, $urandom);
    add_entry(OP_READ,  VLED_ADDR,  '0);
    add_entry(OP_READ,  32'h0000_0000, '0);
    add_entry(OP_DIP,   '0,         32'h0000_a5a5);
  endtask

  // ------------------------------
  // Bus tasks
  // ------------------------------
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    int delay;
    delay = $urandom_range(5, 0);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    @(posedge clk_main_a0);
    while (!awready) @(posedge clk_main_a0);
    awvalid <= 1'b0;
    @(posedge clk_main_a0);
    while (!wready) @(posedge clk_main_a0);
    wvalid <= 1'b0;
    @(posedge clk_main_a0);
    while (!bvalid) @(posedge clk_main_a0);
    // Hold off the response for a while
    repeat (delay) begin
      @(posedge clk_main_a0);
      check_value("bvalid", bvalid, 1);
      check_value("awready", awready, 0);
    end
    bready <= 1'b1;
    @(posedge clk_main_a0);
    check_value("bvalid", bvalid, 1);
    check_value("bresp", bresp, 0);
    bready <= 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    int          delay;
    int          latency;
    logic [31:0] held;
    delay   = $urandom_range(5, 0);
    latency = 0;
    arvalid <= 1'b1;
    araddr  <= addr;
    @(posedge clk_main_a0);
    while (!arready) @(posedge clk_main_a0);
    arvalid <= 1'b0;
    @(posedge clk_main_a0);
    latency++;
    while (!rvalid) begin
      @(posedge clk_main_a0);
      latency++;
    end
    check_value("rvalid latency", latency, 2);
    held = rdata;
    repeat (delay) begin
      @(posedge clk_main_a0);
      check_value("rvalid", rvalid, 1);
      check_value("rdata", rdata, held);
      check_value("arready", arready, 0);
    end
    rready <= 1'b1;
    @(posedge clk_main_a0);
    check_value("rvalid", rvalid, 1);
    check_value("rdata", rdata, held);
    check_value("rresp", rresp, 0);
    rready <= 1'b0;
    data = held;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [31:0] rd;
    void'($urandom(32'h42d3c72b));
    rst_main_n_sync <= 1'b0;
    awvalid         <= 1'b0;
    awaddr          <= '0;
    wvalid          <= 1'b0;
    wdata           <= '0;
    bready          <= 1'b0;
    arvalid         <= 1'b0;
    araddr          <= '0;
    rready          <= 1'b0;
    status_vdip     <= '0;
    build_table();

    repeat (3) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(posedge clk_main_a0);
    check_value("bvalid", bvalid, 0);
    check_value("rvalid", rvalid, 0);
    check_value("status_vled", status_vled, 0);
    check_value("awready", awready, 1);
    check_value("arready", arready, 1);

    for (int i = 0; i < n_entries; i++) begin
      case (tbl_op[i])
        OP_WRITE: write_word(tbl_addr[i], tbl_data[i]);
        OP_READ: begin
          read_word(tbl_addr[i], rd);
          check_value("rdata", rd, tbl_exp_rdata[i]);
        end
        default: status_vdip <= tbl_data[i][15:0];
      endcase
      // Let the LED path and DIP synchronizer settle
      repeat (5) @(posedge clk_main_a0);
      check_value("status_vled", status_vled, tbl_exp_led[i]);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/cl_hello_pkg.sv
hdl/ocl_write_ctrl.sv
hdl/ocl_read_ctrl.sv
hdl/hello_regs.sv
hdl/vdip_led_mask.sv
hdl/cl_hello_top.sv
test/tb_cl_hello.sv
